//--- verilog/serial_alu_defs.svh
`ifndef SERIAL_ALU_DEFS_SVH
`define SERIAL_ALU_DEFS_SVH

// Operand and result width.
`define SALU_WIDTH 16

// Bit counter, wide enough for SALU_WIDTH cycles.
`define SALU_CNT_W 4

`define SALU_OP_W 3

`endif

//--- verilog/serial_alu_pkg.sv
`include "serial_alu_defs.svh"

package serial_alu_pkg;

    // Opcodes 0 to 7.
    typedef enum logic [`SALU_OP_W-1:0] {
        op_add  = 3'd0,
        op_sub  = 3'd1,
        op_xor  = 3'd2,
        op_and  = 3'd3,
        op_not  = 3'd4,
        op_or   = 3'd5,
        op_nor  = 3'd6,
        op_nand = 3'd7
    } alu_op_t;

    typedef struct packed {
        logic [`SALU_WIDTH-1:0] a;
        logic [`SALU_WIDTH-1:0] b;
    } operands_t;

    // One bit of each operand per cycle.
    typedef struct packed {
        logic a_bit;
        logic b_bit;
    } bit_pair_t;

    typedef struct packed {
        logic                   carry;
        logic [`SALU_WIDTH-1:0] value;
    } result_t;

endpackage

//--- verilog/seq_control.sv
`timescale 1ns/10ps
`include "serial_alu_defs.svh"

module seq_control (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic load,
    output logic shift,
    output logic busy,
    output logic done
);

    logic                   busy_q;
    logic                   done_q;
    logic [`SALU_CNT_W-1:0] cnt;
    logic                   last_bit;

    // Start is only taken when idle.
    assign load = start & ~busy_q;

    assign last_bit = (cnt == `SALU_CNT_W'(`SALU_WIDTH - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt    <= '0;
        end else begin
            done_q <= 1'b0;
            if (load) begin
                busy_q <= 1'b1;
                cnt    <= '0;
            end else if (busy_q) begin
                cnt <= cnt + 1'b1;
                // Stop after the last bit.
                if (last_bit) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // One bit is consumed on every busy cycle.
    assign shift = busy_q;
    assign busy  = busy_q;
    assign done  = done_q;

endmodule

//--- verilog/operand_serializer.sv
`timescale 1ns/10ps
`include "serial_alu_defs.svh"

module operand_serializer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      load,
    input  logic                      shift,
    input  serial_alu_pkg::operands_t operands,
    output serial_alu_pkg::bit_pair_t bits
);

    logic [`SALU_WIDTH-1:0] a_sr;
    logic [`SALU_WIDTH-1:0] b_sr;

    // Operands are held here, so the inputs may change mid-operation.
    always_ff @(posedge clk) begin
        if (rst) begin
            a_sr <= '0;
            b_sr <= '0;
        end else if (load) begin
            a_sr <= operands.a;
            b_sr <= operands.b;
        end else if (shift) begin
            a_sr <= {1'b0, a_sr[`SALU_WIDTH-1:1]};
            b_sr <= {1'b0, b_sr[`SALU_WIDTH-1:1]};
        end
    end

    // LSB first.
    assign bits = '{a_bit: a_sr[0], b_bit: b_sr[0]};

endmodule

//--- verilog/bit_alu.sv
`timescale 1ns/10ps

module bit_alu (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      load,
    input  logic                      shift,
    input  serial_alu_pkg::alu_op_t   op,
    input  serial_alu_pkg::bit_pair_t bits,
    output logic                      res_bit,
    output logic                      carry
);

    serial_alu_pkg::alu_op_t op_q;
    logic                    carry_q;
    logic                    is_sub;
    logic                    is_arith;
    logic                    b_eff;
    logic                    sum;
    logic                    cout;

    assign is_sub   = (op_q == serial_alu_pkg::op_sub);
    assign is_arith = is_sub | (op_q == serial_alu_pkg::op_add);

    // SUB is a + ~b with the carry preset to 1.
    assign b_eff = bits.b_bit ^ is_sub;
    assign sum   = bits.a_bit ^ b_eff ^ carry_q;
    assign cout  = (bits.a_bit & b_eff) | (carry_q & (bits.a_bit ^ b_eff));

    always_comb begin
        case (op_q)
            serial_alu_pkg::op_xor:  res_bit = bits.a_bit ^ bits.b_bit;
            serial_alu_pkg::op_and:  res_bit = bits.a_bit & bits.b_bit;
            serial_alu_pkg::op_not:  res_bit = ~bits.a_bit;
            serial_alu_pkg::op_or:   res_bit = bits.a_bit | bits.b_bit;
            serial_alu_pkg::op_nor:  res_bit = ~(bits.a_bit | bits.b_bit);
            serial_alu_pkg::op_nand: res_bit = ~(bits.a_bit & bits.b_bit);
            default:                 res_bit = sum;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            op_q    <= serial_alu_pkg::op_add;
            carry_q <= 1'b0;
        end else if (load) begin
            op_q    <= op;
            carry_q <= (op == serial_alu_pkg::op_sub);
        end else if (shift && is_arith) begin
            carry_q <= cout;
        end
    end

    // Stays 0 for the logic operations.
    assign carry = carry_q;

endmodule

//--- verilog/result_deserializer.sv
`timescale 1ns/10ps
`include "serial_alu_defs.svh"

module result_deserializer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load,
    input  logic                   shift,
    input  logic                   res_bit,
    output logic [`SALU_WIDTH-1:0] value
);

    logic [`SALU_WIDTH-1:0] value_sr;

    // New bits enter at the top and walk down.
    // After the last shift bit 0 is the LSB.
    always_ff @(posedge clk) begin
        if (rst) begin
            value_sr <= '0;
        end else if (load) begin
            value_sr <= '0;
        end else if (shift) begin
            value_sr <= {res_bit, value_sr[`SALU_WIDTH-1:1]};
        end
    end

    // Held between operations.
    assign value = value_sr;

endmodule

//--- verilog/serial_alu.sv
`timescale 1ns/10ps
`include "serial_alu_defs.svh"

module serial_alu (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  serial_alu_pkg::alu_op_t   op,
    input  serial_alu_pkg::operands_t operands,
    output serial_alu_pkg::result_t   result,
    output logic                     busy,
    output logic                     done
);

    logic                      load;
    logic                      shift;
    serial_alu_pkg::bit_pair_t bits;
    logic                      res_bit;
    logic                      carry;
    logic [`SALU_WIDTH-1:0]    value;

    seq_control u_ctrl (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .load  (load),
        .shift (shift),
        .busy  (busy),
        .done  (done)
    );

    operand_serializer u_ser (
        .clk      (clk),
        .rst      (rst),
        .load     (load),
        .shift    (shift),
        .operands (operands),
        .bits     (bits)
    );

    bit_alu u_alu (
        .clk     (clk),
        .rst     (rst),
        .load    (load),
        .shift   (shift),
        .op      (op),
        .bits    (bits),
        .res_bit (res_bit),
        .carry   (carry)
    );

    result_deserializer u_deser (
        .clk     (clk),
        .rst     (rst),
        .load    (load),
        .shift   (shift),
        .res_bit (res_bit),
        .value   (value)
    );

    // Final carry sits above the value as the 17th bit.
    assign result = '{carry: carry, value: value};

endmodule

//--- tb/tb_serial_alu_tasks.svh
`ifndef TB_SERIAL_ALU_TASKS_SVH
`define TB_SERIAL_ALU_TASKS_SVH

// Ends the run at the first failure.
task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at %0t", $time);
endtask

task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
    if (actual !== expected) begin
        stop_with_error($sformatf("Mismatch at time %0t: %s is 0x%0h, expected 0x%0h",
                                  $time, what, actual, expected));
    end
endtask

// Start one operation, count cycles to done and check the result.
task automatic run_vector(input vector_t v, input int idx);
    int    cycles;
    string tag;
    tag = $sformatf("vector %0d", idx);
    @(posedge clk);
    start    <= 1'b1;
    op       <= serial_alu_pkg::alu_op_t'(v.op);
    operands <= v.opnds;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    check_equal(32'(busy), 32'd1, {tag, " busy after start"});
    cycles = 0;
    while (done !== 1'b1) begin
        @(posedge clk);
        cycles = cycles + 1;
        // A second start and new inputs while busy must change nothing.
        if (cycles == 3) begin
            start    <= 1'b1;
            op       <= serial_alu_pkg::alu_op_t'(~v.op);
            operands <= serial_alu_pkg::operands_t'(~v.opnds);
        end else begin
            start <= 1'b0;
        end
        @(negedge clk);
        if (cycles > `SALU_WIDTH + 4) begin
            stop_with_error($sformatf("%s: done never came after the start", tag));
        end
        if (done !== 1'b1) begin
            check_equal(32'(busy), 32'd1, {tag, " busy during operation"});
        end
    end
    check_equal(32'(cycles), 32'(`SALU_WIDTH), {tag, " cycles from start to done"});
    check_equal(32'(busy), 32'd0, {tag, " busy with done"});
    check_equal(32'(result.value), 32'(v.exp_res.value), {tag, " result value"});
    check_equal(32'(result.carry), 32'(v.exp_res.carry), {tag, " result carry"});

    // Done lasts one cycle, the result stays.
    @(posedge clk);
    @(negedge clk);
    check_equal(32'(done), 32'd0, {tag, " done one cycle later"});
    check_equal(32'(busy), 32'd0, {tag, " busy one cycle later"});
    check_equal(32'(result), 32'(v.exp_res), {tag, " held result"});
endtask

`endif

//--- tb/tb_serial_alu.sv
`timescale 1ns/10ps
`include "serial_alu_defs.svh"

module tb_serial_alu;

    // One line of the golden file.
    typedef struct packed {
        logic [`SALU_OP_W-1:0]     op;
        serial_alu_pkg::operands_t opnds;
        serial_alu_pkg::result_t   exp_res;
    } vector_t;

    logic                      clk;
    logic                      rst;
    logic                      start;
    serial_alu_pkg::alu_op_t   op;
    serial_alu_pkg::operands_t operands;
    serial_alu_pkg::result_t   result;
    logic                      busy;
    logic                      done;

    vector_t vectors[$];
    logic    vectors_ready;

    serial_alu DUT (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .op       (op),
        .operands (operands),
        .result   (result),
        .busy     (busy),
        .done     (done)
    );

    `include "tb_serial_alu_tasks.svh"

    always #5 clk = ~clk;

    task automatic load_golden();
        int          fd;
        int          rc;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_a;
        logic [31:0] f_b;
        logic [31:0] f_val;
        logic [31:0] f_cry;
        vector_t     v;
        fd = $fopen("tb/serial_alu_golden.txt", "r");
        if (fd == 0) begin
            stop_with_error("Could not open the golden file tb/serial_alu_golden.txt");
        end
        while (!$feof(fd)) begin
            rc = $fgets(line, fd);
            // Skip blank lines and comment lines.
            if (rc > 0 && line.len() > 1 && line.substr(0, 1) != "//") begin
                rc = $sscanf(line, "%h %h %h %h %h", f_op, f_a, f_b, f_val, f_cry);
                if (rc != 5) begin
                    stop_with_error($sformatf("Unreadable line in golden file: %s", line));
                end
                v.op            = f_op[`SALU_OP_W-1:0];
                v.opnds.a       = f_a[`SALU_WIDTH-1:0];
                v.opnds.b       = f_b[`SALU_WIDTH-1:0];
                v.exp_res.value = f_val[`SALU_WIDTH-1:0];
                v.exp_res.carry = f_cry[0];
                vectors.push_back(v);
            end
        end
        $fclose(fd);
        if (vectors.size() == 0) begin
            stop_with_error("The golden file holds no test vectors");
        end
    endtask

    // Budget is one full operation per vector plus reset and some slack.
    initial begin
        int limit;
        wait (vectors_ready === 1'b1);
        limit = vectors.size() * ((1 << `SALU_CNT_W) + 4) + 8 + 100;
        repeat (limit) @(posedge clk);
        stop_with_error("Timeout: the simulation hung and did not finish all vectors");
    end

    initial begin
        vectors_ready = 1'b0;
        clk           = 1'b0;
        rst           = 1'b1;
        start         = 1'b0;
        op            = serial_alu_pkg::op_add;
        operands      = '0;
        load_golden();
        vectors_ready = 1'b1;

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_equal(32'(busy), 32'd0, "busy after reset");
        check_equal(32'(done), 32'd0, "done after reset");
        check_equal(32'(result), 32'd0, "result after reset");

        foreach (vectors[i]) begin
            run_vector(vectors[i], i);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- serial_alu.f
+incdir+verilog
+incdir+tb
verilog/serial_alu_pkg.sv
verilog/seq_control.sv
verilog/operand_serializer.sv
verilog/bit_alu.sv
verilog/result_deserializer.sv
verilog/serial_alu.sv
tb/tb_serial_alu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the serial ALU testbench with Verilator.
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log
verilator --binary --timing -f serial_alu.f --top-module tb_serial_alu -o tb_serial_alu \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_serial_alu > sim.log 2>&1
cat sim.log

grep -q "ERRORS FOUND" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

//--- tb/serial_alu_golden.txt
// Columns, all hex: opcode, operand a, operand b, expected value, expected carry.
// Opcodes: 0 ADD, 1 SUB, 2 XOR, 3 AND, 4 NOT, 5 OR, 6 NOR, 7 NAND.
0 1234 4321 5555 0
0 FFFF 0001 0000 1
2 0000 0000 0000 0
0 FFFF FFFF FFFE 1
0 AAAA 5555 FFFF 0
0 0000 0000 0000 0
0 7FFF 0001 8000 0
1 0000 0001 FFFF 0
1 1234 1234 0000 1
1 5555 AAAA AAAB 0
1 FFFF 0000 FFFF 1
1 8000 0001 7FFF 1
1 ABCD 1234 9999 1
2 AAAA 5555 FFFF 0
2 FFFF 1234 EDCB 0
3 AAAA FFFF AAAA 0
3 F0F0 3C3C 3030 0
4 AAAA 1234 5555 0
4 0000 FFFF FFFF 0
5 AAAA 5555 FFFF 0
5 1200 0034 1234 0
6 0000 0000 FFFF 0
6 F0F0 0F00 000F 0
7 FFFF FFFF 0000 0
7 AAAA CCCC 7777 0
0 8000 8000 0000 1
3 FFFF FFFF FFFF 0
4 FFFF 0000 0000 0
